// ==== filelist.f ====
src/fp_norm_pkg.sv
src/fp_special_case.sv
src/fp_normalizer.sv
src/fp_rounder.sv
src/norm_round_top.sv
testbench/norm_round_chk.sv
testbench/tb_norm_round.sv

// ==== src/fp_norm_pkg.sv ====
`default_nettype none

package fp_norm_pkg;

  ////////////////////
  // Format constants
  ////////////////////

  localparam int unsigned exp_w64   = 11;   // FP64 exponent field
  localparam int unsigned exp_w32   = 8;    // FP32 exponent field
  localparam int unsigned mant_w64  = 52;   // FP64 fraction field
  localparam int unsigned mant_w32  = 23;   // FP32 fraction field

  // Raw significand from the iteration unit
  // 53-bit window plus 4 extra bits, MSB set means 1.x
  localparam int unsigned mant_in_w = 57;
  localparam int unsigned exp_in_w  = 13;   // Signed biased exponent, room for over/underflow

  localparam int unsigned exp_one64 = 1;    // Biased exponent of smallest normal

  // Canonical quiet NaN fractions
  localparam logic [mant_w64-1:0] qnan64_frac = {1'b1, {(mant_w64-1){1'b0}}};
  localparam logic [mant_w32-1:0] qnan32_frac = {1'b1, {(mant_w32-1){1'b0}}};

  ////////////////////
  // Control encodings
  ////////////////////

  typedef enum logic [2:0] {
    rm_rne = 3'b000,  // Nearest, ties to even
    rm_rtz = 3'b001,  // Toward zero
    rm_rdn = 3'b010,  // Toward -inf
    rm_rup = 3'b011,  // Toward +inf
    rm_rmm = 3'b100   // Nearest, ties away
  } rm_e;

  typedef enum logic {
    fmt_fp64 = 1'b0,
    fmt_fp32 = 1'b1   // NaN-boxed in the 64-bit word
  } fmt_e;

  typedef struct packed {
    logic div;
    logic sqrt;
    rm_e  rm;
    fmt_e fmt;
  } op_ctrl_t;

  // Operand classification from the front end
  typedef struct packed {
    logic nan_a;
    logic nan_b;
    logic snan;     // Any operand is signalling
    logic inf_a;
    logic inf_b;
    logic zero_a;
    logic zero_b;
  } operand_class_t;

  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fflags_t;

  typedef struct packed {
    logic                 sign;
    logic [exp_in_w-1:0]  exp;    // Two's complement
    logic [mant_in_w-1:0] mant;
  } raw_result_t;

  ////////////////////
  // Internal payloads
  ////////////////////

  typedef enum logic [1:0] {
    spec_none,
    spec_nan,
    spec_inf,
    spec_zero
  } spec_kind_e;

  typedef struct packed {
    spec_kind_e kind;
    logic       sign;
    logic       nv;
    logic       dz;
  } special_t;

  typedef struct packed {
    logic                 sign;
    logic [exp_w64-1:0]   exp;      // Biased, FP32 uses low bits
    logic [mant_w64:0]    sig;      // Hidden bit at MSB
    logic [mant_in_w-1:0] tail;     // Shifted-out bits, LSB is sticky
    logic                 special;  // Final value, bypass rounding
    fflags_t              flags;
    op_ctrl_t             ctrl;
  } norm_t;

  // One result word, two views
  typedef union packed {
    struct packed {
      logic                sign;
      logic [exp_w64-1:0]  exp;
      logic [mant_w64-1:0] frac;
    } f64;
    struct packed {
      logic [31:0]         box;   // All ones for a valid FP32
      logic                sign;
      logic [exp_w32-1:0]  exp;
      logic [mant_w32-1:0] frac;
    } f32;
  } fp_result_u;

endpackage

`default_nettype wire

// ==== src/fp_normalizer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_normalizer (
  input  logic                     clk_ci,
  input  logic                     arst_n,
  input  logic                     in_valid,
  input  fp_norm_pkg::op_ctrl_t    ctrl,
  input  fp_norm_pkg::raw_result_t raw,
  input  fp_norm_pkg::special_t    special,
  output logic                     norm_valid,
  output fp_norm_pkg::norm_t       norm
);

  import fp_norm_pkg::*;

  localparam int unsigned sig_w     = mant_w64 + 1;           // 53-bit window
  localparam int unsigned win_w     = sig_w + 2 * mant_in_w;  // Denormal shifter width
  localparam int unsigned shamt_max = sig_w + mant_in_w;      // Beyond this all bits are sticky
  localparam int unsigned shamt_w   = $clog2(shamt_max + 1);

  localparam logic signed [exp_in_w-1:0] exp_max64 = (1 << exp_w64) - 1;
  localparam logic signed [exp_in_w-1:0] exp_max32 = (1 << exp_w32) - 1;

  logic                       top;        // Mantissa in 1.x form
  logic signed [exp_in_w-1:0] exp_s;
  logic signed [exp_in_w-1:0] exp_adj;    // Exponent after 0.1x fixup
  logic signed [exp_in_w-1:0] exp_max;
  logic                       is_sub;
  logic [exp_in_w:0]          shamt_wide;
  logic [shamt_w-1:0]         shamt;
  logic [win_w-1:0]           sub_win;
  norm_t                      norm_d;

  assign top     = raw.mant[mant_in_w-1];
  assign exp_s   = $signed(raw.exp);
  assign exp_adj = top ? exp_s : exp_s - exp_in_w'(1);
  assign exp_max = (ctrl.fmt == fmt_fp32) ? exp_max32 : exp_max64;

  // Denormal when exponent <= 0, or exactly 1 with 0.1x mantissa
  assign is_sub = (exp_s <= 0) || ((raw.exp == exp_in_w'(exp_one64)) && !top);

  ////////////////////
  // Denormal shifter
  ////////////////////

  // Shift by 1 - exp, sign-extended so -4096 still fits
  assign shamt_wide = (exp_in_w + 1)'(1) - {raw.exp[exp_in_w-1], raw.exp};
  assign shamt      = (shamt_wide > shamt_max) ? shamt_w'(shamt_max)
                                               : shamt_wide[shamt_w-1:0];

  assign sub_win = {raw.mant, {(win_w - mant_in_w){1'b0}}} >> shamt;

  ////////////////////
  // Case select
  ////////////////////

  always_comb
  begin
    norm_d      = '0;
    norm_d.sign = raw.sign;
    norm_d.ctrl = ctrl;

    if (special.kind != spec_none)
    begin
      norm_d.special  = 1'b1;
      norm_d.sign     = special.sign;
      norm_d.flags.nv = special.nv;
      norm_d.flags.dz = special.dz;
      if (special.kind == spec_nan)
      begin
        norm_d.exp = '1;
        norm_d.sig = (ctrl.fmt == fmt_fp32)
                   ? {1'b0, qnan32_frac, {(mant_w64 - mant_w32){1'b0}}}
                   : {1'b0, qnan64_frac};
      end
      else if (special.kind == spec_inf)
      begin
        norm_d.exp = '1;  // Zero fraction
      end
    end
    else if (raw.mant == '0)
    begin
      norm_d.special = 1'b1;   // Signed zero, exact
    end
    else if (is_sub)
    begin
      norm_d.sig      = sub_win[win_w-1 -: sig_w];
      norm_d.tail     = {sub_win[win_w-sig_w-1 -: mant_in_w-1], |sub_win[mant_in_w:0]};
      norm_d.flags.uf = 1'b1;  // Kept only if inexact later
    end
    else if (exp_adj >= exp_max)
    begin
      norm_d.special  = 1'b1;  // Overflow to infinity
      norm_d.exp      = '1;
      norm_d.flags.of = 1'b1;
      norm_d.flags.nx = 1'b1;
    end
    else if (top)
    begin
      norm_d.exp  = exp_adj[exp_w64-1:0];
      norm_d.sig  = raw.mant[mant_in_w-1 -: sig_w];
      norm_d.tail = {raw.mant[mant_in_w-sig_w-1:0], {sig_w{1'b0}}};
    end
    else
    begin
      norm_d.exp  = exp_adj[exp_w64-1:0];       // One below input
      norm_d.sig  = raw.mant[mant_in_w-2 -: sig_w];
      norm_d.tail = {raw.mant[mant_in_w-sig_w-2:0], {(sig_w + 1){1'b0}}};
    end
  end

  ////////////////////
  // Stage-1 register
  ////////////////////

  always_ff @(posedge clk_ci or negedge arst_n)
  begin
    if (!arst_n)
    begin
      norm_valid <= 1'b0;
    end
    else
    begin
      norm_valid <= in_valid;
    end
  end

  always_ff @(posedge clk_ci)
  begin
    if (in_valid)
    begin
      norm <= norm_d;  // Payload only moves with a strobe
    end
  end

endmodule

`default_nettype wire

// ==== src/fp_rounder.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_rounder (
  input  logic                   clk_ci,
  input  logic                   arst_n,
  input  logic                   norm_valid,
  input  fp_norm_pkg::norm_t     norm,
  output logic                   out_valid,
  output fp_norm_pkg::fp_result_u result,
  output fp_norm_pkg::fflags_t   fflags
);

  import fp_norm_pkg::*;

  localparam int unsigned sig_w = mant_w64 + 1;
  localparam int unsigned lsb32 = mant_w64 - mant_w32;  // FP32 ulp position in sig

  localparam logic [exp_w64-1:0] exp_inf64 = '1;
  localparam logic [exp_w64-1:0] exp_inf32 = (1 << exp_w32) - 1;

  logic                is_fp32;
  logic                lsb;
  logic                guard;
  logic                sticky;
  logic                inexact;
  logic                round_up;
  logic [sig_w:0]      inc;
  logic [sig_w:0]      sig_rnd;       // One extra bit for carry
  logic                carry;
  logic                exp_bump;
  logic [exp_w64-1:0]  exp_rnd;
  logic                ovf;
  logic                res_sign;
  logic [exp_w64-1:0]  res_exp;
  logic [mant_w64-1:0] res_frac64;
  logic [mant_w32-1:0] res_frac32;
  fflags_t             flags_d;
  fp_result_u          result_d;

  assign is_fp32 = (norm.ctrl.fmt == fmt_fp32);

  ////////////////////
  // Guard and sticky
  ////////////////////

  always_comb
  begin
    if (is_fp32)
    begin
      lsb    = norm.sig[lsb32];
      guard  = norm.sig[lsb32-1];
      sticky = (|norm.sig[lsb32-2:0]) | (|norm.tail);  // Tail counts too
    end
    else
    begin
      lsb    = norm.sig[0];
      guard  = norm.tail[mant_in_w-1];
      sticky = |norm.tail[mant_in_w-2:0];
    end
  end

  assign inexact = guard | sticky;

  // Round-up decision per mode
  always_comb
  begin
    case (norm.ctrl.rm)
      rm_rne:  round_up = guard & (sticky | lsb);  // Tie goes to even
      rm_rtz:  round_up = 1'b0;
      rm_rdn:  round_up = inexact & norm.sign;     // Magnitude grows if negative
      rm_rup:  round_up = inexact & ~norm.sign;
      rm_rmm:  round_up = guard;                   // Tie goes away from zero
      default: round_up = 1'b0;
    endcase
  end

  ////////////////////
  // Increment and renormalize
  ////////////////////

  assign inc     = is_fp32 ? ((sig_w + 1)'(1) << lsb32) : (sig_w + 1)'(1);
  assign sig_rnd = {1'b0, norm.sig} + (round_up ? inc : '0);
  assign carry   = sig_rnd[sig_w];

  // Carry out, or a denormal that reached the hidden bit
  assign exp_bump = carry | ((norm.exp == '0) & sig_rnd[sig_w-1]);
  assign exp_rnd  = norm.exp + exp_w64'(exp_bump);
  assign ovf      = exp_bump & (exp_rnd == (is_fp32 ? exp_inf32 : exp_inf64));

  always_comb
  begin
    flags_d    = norm.flags;
    res_sign   = norm.sign;
    res_exp    = norm.exp;
    res_frac64 = norm.sig[mant_w64-1:0];         // Special values as built
    res_frac32 = norm.sig[sig_w-2 -: mant_w32];

    if (!norm.special)
    begin
      res_exp    = exp_rnd;
      res_frac64 = carry ? sig_rnd[sig_w-1:1] : sig_rnd[sig_w-2:0];
      res_frac32 = carry ? sig_rnd[sig_w-1 -: mant_w32] : sig_rnd[sig_w-2 -: mant_w32];
      flags_d.nx = inexact;
      flags_d.uf = norm.flags.uf & inexact;     // Tiny and exact is no underflow
      if (ovf)
      begin
        res_frac64 = '0;                         // Rounded up into infinity
        res_frac32 = '0;
        flags_d.of = 1'b1;
        flags_d.nx = 1'b1;
      end
    end

    ////////////////////
    // Packing
    ////////////////////
    if (is_fp32)
    begin
      result_d.f32.box  = '1;                    // NaN boxing
      result_d.f32.sign = res_sign;
      result_d.f32.exp  = res_exp[exp_w32-1:0];
      result_d.f32.frac = res_frac32;
    end
    else
    begin
      result_d.f64.sign = res_sign;
      result_d.f64.exp  = res_exp;
      result_d.f64.frac = res_frac64;
    end
  end

  ////////////////////
  // Stage-2 register
  ////////////////////

  always_ff @(posedge clk_ci or negedge arst_n)
  begin
    if (!arst_n)
    begin
      out_valid <= 1'b0;
      result    <= '0;
      fflags    <= '0;
    end
    else
    begin
      out_valid <= norm_valid;
      if (norm_valid)
      begin
        result <= result_d;  // Hold last result otherwise
        fflags <= flags_d;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/fp_special_case.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp_special_case (
  input  fp_norm_pkg::op_ctrl_t       ctrl,
  input  fp_norm_pkg::operand_class_t cls,
  input  logic                        sign,
  output fp_norm_pkg::special_t       special
);

  import fp_norm_pkg::*;

  ////////////////////
  // Priority classifier
  ////////////////////

  always_comb
  begin
    special      = '0;           // spec_none, no flags
    special.sign = sign;

    if (cls.nan_a || cls.nan_b)
    begin
      special.kind = spec_nan;
      special.nv   = cls.snan;   // Quiet NaN propagates silently
    end
    else if (cls.inf_a && ((ctrl.div && cls.inf_b) || (ctrl.sqrt && sign)))
    begin
      special.kind = spec_nan;   // inf/inf or sqrt(-inf)
      special.nv   = 1'b1;
    end
    else if (cls.inf_a)
    begin
      special.kind = spec_inf;   // Exact infinity, no OF
    end
    else if (ctrl.div && cls.inf_b)
    begin
      special.kind = spec_zero;  // x/inf
    end
    else if (ctrl.div && cls.zero_a && cls.zero_b)
    begin
      special.kind = spec_nan;   // 0/0 is invalid only
      special.nv   = 1'b1;
    end
    else if (cls.zero_a)
    begin
      special.kind = spec_zero;  // Also covers sqrt(-0) = -0
    end
    else if (ctrl.div && cls.zero_b)
    begin
      special.kind = spec_inf;
      special.dz   = 1'b1;       // Finite / 0
    end
    else if (ctrl.sqrt && sign)
    begin
      special.kind = spec_nan;   // Root of negative
      special.nv   = 1'b1;
    end

    // Canonical NaN is positive
    if (special.kind == spec_nan)
    begin
      special.sign = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== src/norm_round_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module norm_round_top (
  input  logic                        clk_ci,
  input  logic                        arst_n,
  input  logic                        in_valid,   // One-cycle strobe
  input  fp_norm_pkg::op_ctrl_t       ctrl,
  input  fp_norm_pkg::operand_class_t cls,
  input  fp_norm_pkg::raw_result_t    raw,
  output logic                        out_valid,  // Two cycles after in_valid
  output fp_norm_pkg::fp_result_u     result,
  output fp_norm_pkg::fflags_t        fflags
);

  import fp_norm_pkg::*;

  special_t special;     // Classifier to normalizer
  logic     norm_valid;
  norm_t    norm;        // Stage-1 payload

  ////////////////////
  // Special operands
  ////////////////////

  fp_special_case u_special (
    .ctrl    (ctrl),
    .cls     (cls),
    .sign    (raw.sign),
    .special (special)
  );

  ////////////////////
  // Stage 1
  ////////////////////

  fp_normalizer u_norm (
    .clk_ci     (clk_ci),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .ctrl       (ctrl),
    .raw        (raw),
    .special    (special),
    .norm_valid (norm_valid),
    .norm       (norm)
  );

  ////////////////////
  // Stage 2
  ////////////////////

  fp_rounder u_round (
    .clk_ci     (clk_ci),
    .arst_n     (arst_n),
    .norm_valid (norm_valid),
    .norm       (norm),
    .out_valid  (out_valid),
    .result     (result),
    .fflags     (fflags)
  );

endmodule

`default_nettype wire

// ==== testbench/norm_round_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module norm_round_chk (
  input logic                    clk_ci,
  input logic                    arst_n,
  input logic                    in_valid,
  input fp_norm_pkg::op_ctrl_t   ctrl,
  input logic                    norm_valid,
  input fp_norm_pkg::norm_t      norm,
  input logic                    out_valid,
  input fp_norm_pkg::fp_result_u result,
  input fp_norm_pkg::fflags_t    fflags
);

  import fp_norm_pkg::*;

  int assert_errs = 0;  // Failure count for the closing summary

  ////////////////////
  // Pipeline timing
  ////////////////////

  a_latency : assert property (@(posedge clk_ci) disable iff (!arst_n)
      out_valid == $past(in_valid, 2))
    else
    begin
      assert_errs++;
      $error("out_valid is not in_valid delayed by two cycles");
    end

  a_reset_low : assert property (@(posedge clk_ci) !arst_n |-> !out_valid)
    else
    begin
      assert_errs++;
      $error("out_valid is high while reset is asserted");
    end

  ////////////////////
  // Result contents
  ////////////////////

  // Special values are exact, invalid never comes with inexact
  a_special_flags : assert property (@(posedge clk_ci) disable iff (!arst_n)
      (norm_valid && norm.special) |=> !(fflags.nv && fflags.nx))
    else
    begin
      assert_errs++;
      $error("special result raised both nv and nx");
    end

  a_nan_box : assert property (@(posedge clk_ci) disable iff (!arst_n)
      (out_valid && ($past(ctrl.fmt, 2) == fmt_fp32)) |-> (result.f32.box == '1))
    else
    begin
      assert_errs++;
      $error("FP32 result is not NaN-boxed");
    end

endmodule

bind norm_round_top norm_round_chk i_chk (
  .clk_ci     (clk_ci),
  .arst_n     (arst_n),
  .in_valid   (in_valid),
  .ctrl       (ctrl),
  .norm_valid (norm_valid),
  .norm       (norm),
  .out_valid  (out_valid),
  .result     (result),
  .fflags     (fflags)
);

`default_nettype wire

// ==== testbench/tb_norm_round.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_norm_round;

  import fp_norm_pkg::*;

  localparam int unsigned n_vec    = 34;
  localparam int unsigned idle_max = 20;  // Drain limit after the last issue

  logic           clk_ci;
  logic           arst_n;
  logic           in_valid;
  op_ctrl_t       ctrl;
  operand_class_t cls;
  raw_result_t    raw;
  logic           out_valid;
  fp_result_u     result;
  fflags_t        fflags;

  // Vector table
  string          vec_name   [n_vec];
  op_ctrl_t       vec_ctrl   [n_vec];
  operand_class_t vec_cls    [n_vec];
  raw_result_t    vec_raw    [n_vec];
  fp_result_u     vec_result [n_vec];
  fflags_t        vec_flags  [n_vec];
  int             n_loaded;

  int pend_idx [$];  // In flight, oldest first
  int pend_cyc [$];  // Issue cycle of each
  int cyc;
  int n_checked;
  int result_errs;
  int flag_errs;
  int other_errs;

  norm_round_top i_dut (
    .clk_ci    (clk_ci),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .ctrl      (ctrl),
    .cls       (cls),
    .raw       (raw),
    .out_valid (out_valid),
    .result    (result),
    .fflags    (fflags)
  );

  initial
  begin
    clk_ci = 1'b0;
    forever
    begin
      #2 clk_ci = ~clk_ci;  // 4 ns period
    end
  end

  ////////////////////
  // Table helpers
  ////////////////////

  function automatic op_ctrl_t make_ctrl(input logic is_div, input logic is_sqrt,
                                         input rm_e rm, input fmt_e fmt);
    op_ctrl_t c;
    c.div  = is_div;
    c.sqrt = is_sqrt;
    c.rm   = rm;
    c.fmt  = fmt;
    return c;
  endfunction

  task automatic load_vector(input string name, input op_ctrl_t c, input operand_class_t k,
                             input logic sign, input logic [exp_in_w-1:0] e,
                             input logic [mant_in_w-1:0] m, input fp_result_u res,
                             input fflags_t fl);
    vec_name[n_loaded]   = name;
    vec_ctrl[n_loaded]   = c;
    vec_cls[n_loaded]    = k;
    vec_raw[n_loaded]    = {sign, e, m};
    vec_result[n_loaded] = res;
    vec_flags[n_loaded]  = fl;
    n_loaded++;
  endtask

  ////////////////////
  // Compare tasks
  ////////////////////

  task automatic check_result(input string name, input fp_result_u want, input fp_result_u got);
    if (got !== want)
    begin
      $display("[FAIL] %s result expected %h actual %h", name, want, got);
      result_errs++;
    end
  endtask

  task automatic check_flags(input string name, input fflags_t want, input fflags_t got);
    if (got !== want)
    begin
      $display("[FAIL] %s fflags expected %b actual %b", name, want, got);
      flag_errs++;
    end
  endtask

  // Pops one expected entry per out_valid
  task automatic collect_output();
    int idx;
    int issued;
    if (out_valid === 1'b1)
    begin
      if (pend_idx.size() == 0)
      begin
        $display("Error: out_valid high with nothing in flight at cycle %0d", cyc);
        other_errs++;
      end
      else
      begin
        idx    = pend_idx.pop_front();
        issued = pend_cyc.pop_front();
        if (cyc - issued != 2)
        begin
          $display("Error: %s came out %0d cycles after issue, not 2", vec_name[idx],
                   cyc - issued);
          other_errs++;
        end
        check_result(vec_name[idx], vec_result[idx], result);
        check_flags(vec_name[idx], vec_flags[idx], fflags);
        n_checked++;
      end
    end
    else if (out_valid !== 1'b0)
    begin
      $display("Error: out_valid is unknown at cycle %0d", cyc);
      other_errs++;
    end
  endtask

  task automatic drive_vector(input int idx);
    in_valid = 1'b1;
    ctrl     = vec_ctrl[idx];
    cls      = vec_cls[idx];
    raw      = vec_raw[idx];
    pend_idx.push_back(idx);
    pend_cyc.push_back(cyc);
  endtask

  ////////////////////
  // Expected values
  ////////////////////

  task automatic load_table();
    // Special operands
    load_vector("qnan_prop", make_ctrl(1, 0, rm_rne, fmt_fp64), 7'b1000000,
                1'b1, 13'h3FF, 57'h180000000000000, 64'h7FF8_0000_0000_0000, 5'b00000);
    load_vector("snan_prop_fp32", make_ctrl(1, 0, rm_rne, fmt_fp32), 7'b0110000,
                1'b0, 13'h07F, 57'h180000000000000, 64'hFFFF_FFFF_7FC0_0000, 5'b10000);
    load_vector("inf_div_inf", make_ctrl(1, 0, rm_rne, fmt_fp64), 7'b0001100,
                1'b1, 13'h3FF, 57'h180000000000000, 64'h7FF8_0000_0000_0000, 5'b10000);
    load_vector("inf_div_finite", make_ctrl(1, 0, rm_rne, fmt_fp32), 7'b0001000,
                1'b1, 13'h07F, 57'h180000000000000, 64'hFFFF_FFFF_FF80_0000, 5'b00000);
    load_vector("zero_div_zero", make_ctrl(1, 0, rm_rne, fmt_fp64), 7'b0000011,
                1'b0, 13'h000, 57'h000000000000000, 64'h7FF8_0000_0000_0000, 5'b10000);
    load_vector("x_div_zero", make_ctrl(1, 0, rm_rne, fmt_fp64), 7'b0000001,
                1'b1, 13'h3FF, 57'h180000000000000, 64'hFFF0_0000_0000_0000, 5'b01000);
    load_vector("x_div_inf", make_ctrl(1, 0, rm_rne, fmt_fp64), 7'b0000100,
                1'b1, 13'h3FF, 57'h180000000000000, 64'h8000_0000_0000_0000, 5'b00000);
    load_vector("sqrt_neg", make_ctrl(0, 1, rm_rne, fmt_fp64), 7'b0000000,
                1'b1, 13'h3FF, 57'h180000000000000, 64'h7FF8_0000_0000_0000, 5'b10000);
    load_vector("zero_mant", make_ctrl(1, 0, rm_rne, fmt_fp32), 7'b0000000,
                1'b1, 13'h000, 57'h000000000000000, 64'hFFFF_FFFF_8000_0000, 5'b00000);
    // Exact normals, 1.x and 0.1x
    load_vector("fp64_top", make_ctrl(1, 0, rm_rne, fmt_fp64), 7'b0000000,
                1'b0, 13'h3FF, 57'h180000000000000, 64'h3FF8_0000_0000_0000, 5'b00000);
    load_vector("fp64_low", make_ctrl(1, 0, rm_rne, fmt_fp64), 7'b0000000,
                1'b1, 13'h400, 57'h0A0000000000000, 64'hBFF4_0000_0000_0000, 5'b00000);
    load_vector("fp32_top", make_ctrl(1, 0, rm_rne, fmt_fp32), 7'b0000000,
                1'b0, 13'h07F, 57'h180000000000000, 64'hFFFF_FFFF_3FC0_0000, 5'b00000);
    load_vector("fp32_low", make_ctrl(1, 0, rm_rne, fmt_fp32), 7'b0000000,
                1'b1, 13'h081, 57'h0E0000000000000, 64'hFFFF_FFFF_C060_0000, 5'b00000);
    // Tie with even lsb, all modes and both signs
    load_vector("rne_pos", make_ctrl(1, 0, rm_rne, fmt_fp64), 7'b0000000,
                1'b0, 13'h3FF, 57'h100000000000028, 64'h3FF0_0000_0000_0002, 5'b00001);
    load_vector("rtz_pos", make_ctrl(1, 0, rm_rtz, fmt_fp64), 7'b0000000,
                1'b0, 13'h3FF, 57'h100000000000028, 64'h3FF0_0000_0000_0002, 5'b00001);
    load_vector("rdn_pos", make_ctrl(1, 0, rm_rdn, fmt_fp64), 7'b0000000,
                1'b0, 13'h3FF, 57'h100000000000028, 64'h3FF0_0000_0000_0002, 5'b00001);
    load_vector("rup_pos", make_ctrl(1, 0, rm_rup, fmt_fp64), 7'b0000000,
                1'b0, 13'h3FF, 57'h100000000000028, 64'h3FF0_0000_0000_0003, 5'b00001);
    load_vector("rmm_pos", make_ctrl(1, 0, rm_rmm, fmt_fp64), 7'b0000000,
                1'b0, 13'h3FF, 57'h100000000000028, 64'h3FF0_0000_0000_0003, 5'b00001);
    load_vector("rne_neg", make_ctrl(1, 0, rm_rne, fmt_fp64), 7'b0000000,
                1'b1, 13'h3FF, 57'h100000000000028, 64'hBFF0_0000_0000_0002, 5'b00001);
    load_vector("rtz_neg", make_ctrl(1, 0, rm_rtz, fmt_fp64), 7'b0000000,
                1'b1, 13'h3FF, 57'h100000000000028, 64'hBFF0_0000_0000_0002, 5'b00001);
    load_vector("rdn_neg", make_ctrl(1, 0, rm_rdn, fmt_fp64), 7'b0000000,
                1'b1, 13'h3FF, 57'h100000000000028, 64'hBFF0_0000_0000_0003, 5'b00001);
    load_vector("rup_neg", make_ctrl(1, 0, rm_rup, fmt_fp64), 7'b0000000,
                1'b1, 13'h3FF, 57'h100000000000028, 64'hBFF0_0000_0000_0002, 5'b00001);
    load_vector("rmm_neg", make_ctrl(1, 0, rm_rmm, fmt_fp64), 7'b0000000,
                1'b1, 13'h3FF, 57'h100000000000028, 64'hBFF0_0000_0000_0003, 5'b00001);
    load_vector("rne_tie_odd", make_ctrl(1, 0, rm_rne, fmt_fp64), 7'b0000000,
                1'b0, 13'h3FF, 57'h100000000000038, 64'h3FF0_0000_0000_0004, 5'b00001);
    load_vector("rne_above_half", make_ctrl(1, 0, rm_rne, fmt_fp64), 7'b0000000,
                1'b0, 13'h3FF, 57'h100000000000029, 64'h3FF0_0000_0000_0003, 5'b00001);
    load_vector("fp32_tail_sticky", make_ctrl(1, 0, rm_rne, fmt_fp32), 7'b0000000,
                1'b0, 13'h07F, 57'h100000100000001, 64'hFFFF_FFFF_3F80_0001, 5'b00001);
    // Rounding carry
    load_vector("carry_renorm", make_ctrl(1, 0, rm_rne, fmt_fp64), 7'b0000000,
                1'b0, 13'h3FF, 57'h1FFFFFFFFFFFFF8, 64'h4000_0000_0000_0000, 5'b00001);
    load_vector("carry_to_inf", make_ctrl(1, 0, rm_rne, fmt_fp64), 7'b0000000,
                1'b0, 13'h7FE, 57'h1FFFFFFFFFFFFF8, 64'h7FF0_0000_0000_0000, 5'b00101);
    // Overflow
    load_vector("ovf_fp64", make_ctrl(1, 0, rm_rne, fmt_fp64), 7'b0000000,
                1'b1, 13'h800, 57'h180000000000000, 64'hFFF0_0000_0000_0000, 5'b00101);
    load_vector("ovf_fp32", make_ctrl(1, 0, rm_rne, fmt_fp32), 7'b0000000,
                1'b0, 13'h0FF, 57'h180000000000000, 64'hFFFF_FFFF_7F80_0000, 5'b00101);
    // Subnormals
    load_vector("sub_exact", make_ctrl(1, 0, rm_rne, fmt_fp64), 7'b0000000,
                1'b0, 13'h1FFF, 57'h180000000000000, 64'h0006_0000_0000_0000, 5'b00000);
    load_vector("sub_inexact", make_ctrl(1, 0, rm_rne, fmt_fp64), 7'b0000000,
                1'b1, 13'h1FFF, 57'h180000000000021, 64'h8006_0000_0000_0001, 5'b00011);
    load_vector("sub_to_normal", make_ctrl(1, 0, rm_rne, fmt_fp64), 7'b0000000,
                1'b0, 13'h0000, 57'h1FFFFFFFFFFFFFF, 64'h0010_0000_0000_0000, 5'b00011);
    load_vector("exp_one_low", make_ctrl(1, 0, rm_rne, fmt_fp64), 7'b0000000,
                1'b0, 13'h0001, 57'h0C0000000000000, 64'h000C_0000_0000_0000, 5'b00000);
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial
  begin
    int issue;
    int idle;
    arst_n      = 1'b0;
    in_valid    = 1'b0;
    ctrl        = '0;
    cls         = '0;
    raw         = '0;
    n_loaded    = 0;
    cyc         = 0;
    n_checked   = 0;
    result_errs = 0;
    flag_errs   = 0;
    other_errs  = 0;
    load_table();

    repeat (5) @(posedge clk_ci);
    if (out_valid !== 1'b0)
    begin
      $display("Error: out_valid is not low during reset");
      other_errs++;
    end
    @(negedge clk_ci);
    arst_n = 1'b1;

    // Back to back issue, then drain
    issue = 0;
    idle  = 0;
    while (((issue < n_vec) || (pend_idx.size() != 0)) && (idle < idle_max))
    begin
      @(negedge clk_ci);
      cyc++;
      collect_output();
      if (issue < n_vec)
      begin
        drive_vector(issue);
        issue++;
      end
      else
      begin
        in_valid = 1'b0;
        idle++;
      end
    end
    if (pend_idx.size() != 0)
    begin
      $display("Error: timed out with %0d results still missing", pend_idx.size());
      other_errs++;
    end

    $display("Checked %0d of %0d: %0d result, %0d flag, %0d other, %0d assertion errors",
             n_checked, n_vec, result_errs, flag_errs, other_errs,
             i_dut.i_chk.assert_errs);
    if ((result_errs + flag_errs + other_errs + i_dut.i_chk.assert_errs) == 0)
    begin
      $display("Regression passed");
    end
    else
    begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
